// File: hw/exec_pkg.sv
`default_nettype none

package exec_pkg;

    localparam int XLEN       = 32;         // Data word width
    localparam int REG_ADDR_W = 5;          // Register number width
    localparam int STRB_W     = 4;          // Byte lanes per word

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLT,
        ALU_SLTU,
        ALU_AND,
        ALU_OR,
        ALU_NOR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_LUI                             // Passes operand 2 unchanged
    } alu_op_e;

    typedef enum logic {
        SRC1_RF,
        SRC1_PC
    } src1_sel_e;

    typedef enum logic {
        SRC2_RF,
        SRC2_IMM
    } src2_sel_e;

    typedef enum logic [1:0] {
        MEM_NONE,
        MEM_LOAD,
        MEM_STORE
    } mem_op_e;

    typedef enum logic [2:0] {
        SIZE_B,
        SIZE_H,
        SIZE_W,
        SIZE_BU,
        SIZE_HU
    } mem_size_e;

    // One lane as it enters execute, register data possibly stale
    typedef struct packed {
        logic [XLEN-1:0]       pc;
        logic [XLEN-1:0]       rdata1;
        logic [XLEN-1:0]       rdata2;
        logic [REG_ADDR_W-1:0] raddr1;
        logic [REG_ADDR_W-1:0] raddr2;
        logic [XLEN-1:0]       imm;
        src1_sel_e             src1_sel;
        src2_sel_e             src2_sel;
        alu_op_e               alu_op;
        logic                  rf_we;
        logic [REG_ADDR_W-1:0] waddr;
    } lane_ex_t;

    typedef struct packed {
        mem_op_e   mem_op;
        mem_size_e mem_size;
    } mem_ctl_t;                            // Lane B only

    typedef struct packed {
        logic                  we;
        logic [REG_ADDR_W-1:0] waddr;
        logic [XLEN-1:0]       wdata;
    } wb_port_t;

    typedef struct packed {
        logic              we;
        logic [XLEN-1:0]   addr;
        logic [XLEN-1:0]   wdata;
        logic [STRB_W-1:0] wstrb;
    } dmem_req_t;

endpackage

`default_nettype wire

// File: hw/operand_forward.sv
`timescale 1ns/10ps
`default_nettype none

module operand_forward (
    input  exec_pkg::lane_ex_t             ex_a,
    input  exec_pkg::lane_ex_t             ex_b,
    input  exec_pkg::wb_port_t             mem_a,
    input  exec_pkg::wb_port_t             mem_b,
    input  exec_pkg::wb_port_t             wb_a,
    input  exec_pkg::wb_port_t             wb_b,
    output logic [exec_pkg::XLEN-1:0]      op_a1,
    output logic [exec_pkg::XLEN-1:0]      op_a2,
    output logic [exec_pkg::XLEN-1:0]      op_b1,
    output logic [exec_pkg::XLEN-1:0]      op_b2
);

    import exec_pkg::*;

    function automatic logic hit(input wb_port_t port, input logic [REG_ADDR_W-1:0] raddr);
        return port.we && (port.waddr == raddr);
    endfunction

    // Newest in-flight writer wins; younger lane B beats lane A in each stage
    function automatic logic [XLEN-1:0] pick(
        input logic [REG_ADDR_W-1:0] raddr,
        input logic [XLEN-1:0]       rdata,
        input wb_port_t              m_a,
        input wb_port_t              m_b,
        input wb_port_t              w_a,
        input wb_port_t              w_b
    );
        logic [XLEN-1:0] value;
        value = rdata;
        if (raddr != '0) begin              // r0 stays as supplied
            if (hit(m_b, raddr)) begin
                value = m_b.wdata;
            end else if (hit(m_a, raddr)) begin
                value = m_a.wdata;
            end else if (hit(w_b, raddr)) begin
                value = w_b.wdata;
            end else if (hit(w_a, raddr)) begin
                value = w_a.wdata;
            end
        end
        return value;
    endfunction

    // No A-to-B path inside a pair, issue never pairs dependent ops
    assign op_a1 = pick(ex_a.raddr1, ex_a.rdata1, mem_a, mem_b, wb_a, wb_b);
    assign op_a2 = pick(ex_a.raddr2, ex_a.rdata2, mem_a, mem_b, wb_a, wb_b);
    assign op_b1 = pick(ex_b.raddr1, ex_b.rdata1, mem_a, mem_b, wb_a, wb_b);
    assign op_b2 = pick(ex_b.raddr2, ex_b.rdata2, mem_a, mem_b, wb_a, wb_b);

endmodule

`default_nettype wire

// File: hw/int_alu.sv
`timescale 1ns/10ps
`default_nettype none

module int_alu (
    input  exec_pkg::lane_ex_t        lane,
    input  logic [exec_pkg::XLEN-1:0] op1,     // Forwarded register operands
    input  logic [exec_pkg::XLEN-1:0] op2,
    output logic [exec_pkg::XLEN-1:0] result
);

    import exec_pkg::*;

    logic [XLEN-1:0] src1;
    logic [XLEN-1:0] src2;
    logic [4:0]      shamt;
    logic            lt_signed;
    logic            lt_unsigned;

    assign src1  = (lane.src1_sel == SRC1_PC)  ? lane.pc  : op1;
    assign src2  = (lane.src2_sel == SRC2_IMM) ? lane.imm : op2;
    assign shamt = src2[4:0];                  // Shift amount from low bits only

    assign lt_signed   = $signed(src1) < $signed(src2);
    assign lt_unsigned = src1 < src2;

    always_comb begin
        case (lane.alu_op)
            ALU_ADD: begin
                result = src1 + src2;
            end
            ALU_SUB: begin
                result = src1 - src2;
            end
            ALU_SLT: begin
                result = {{(XLEN-1){1'b0}}, lt_signed};
            end
            ALU_SLTU: begin
                result = {{(XLEN-1){1'b0}}, lt_unsigned};
            end
            ALU_AND: result = src1 & src2;
            ALU_OR:  result = src1 | src2;
            ALU_NOR: result = ~(src1 | src2);
            ALU_XOR: result = src1 ^ src2;
            ALU_SLL: result = src1 << shamt;
            ALU_SRL: result = src1 >> shamt;
            ALU_SRA: begin
                result = $unsigned($signed(src1) >>> shamt);  // Sign fill
            end
            ALU_LUI: begin
                result = src2;                 // Immediate already shifted by decode
            end
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: hw/load_store_unit.sv
`timescale 1ns/10ps
`default_nettype none

module load_store_unit (
    input  logic                      clk,
    input  logic                      rst,
    input  logic [exec_pkg::XLEN-1:0] addr,        // Lane B ALU result
    input  logic [exec_pkg::XLEN-1:0] store_data,  // Lane B forwarded operand 2
    input  exec_pkg::mem_ctl_t        mem_ctl,
    input  logic                      dmem_ready,
    input  logic [exec_pkg::XLEN-1:0] dmem_rdata,
    output logic                      dmem_valid,
    output exec_pkg::dmem_req_t       dmem_req,
    output logic                      stall,
    output logic [exec_pkg::XLEN-1:0] load_data
);

    import exec_pkg::*;

    logic              is_store;
    logic              load_accept;
    logic [XLEN-1:0]   st_wdata;
    logic [STRB_W-1:0] st_strb;
    logic [1:0]        off_q;                  // Byte offset of load in MEM
    mem_size_e         size_q;
    logic [7:0]        rd_byte;
    logic [15:0]       rd_half;

    assign dmem_valid  = (mem_ctl.mem_op != MEM_NONE);
    assign is_store    = (mem_ctl.mem_op == MEM_STORE);
    assign load_accept = dmem_valid && dmem_ready && !is_store;
    assign stall       = dmem_valid && !dmem_ready;  // Same-cycle back-pressure

    // Replicate store data across the word, strobe picks the lanes
    always_comb begin
        case (mem_ctl.mem_size)
            SIZE_B, SIZE_BU: begin
                st_wdata = {4{store_data[7:0]}};
                st_strb  = 4'b0001 << addr[1:0];
            end
            SIZE_H, SIZE_HU: begin
                st_wdata = {2{store_data[15:0]}};
                st_strb  = addr[1] ? 4'b1100 : 4'b0011;
            end
            default: begin
                st_wdata = store_data;
                st_strb  = 4'b1111;
            end
        endcase
    end

    always_comb begin
        dmem_req.we    = is_store;
        dmem_req.addr  = addr;
        dmem_req.wdata = st_wdata;
        dmem_req.wstrb = is_store ? st_strb : '0;  // Loads carry no strobe
    end

    // Remember where the load sits in the word for the MEM cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            off_q  <= '0;
            size_q <= SIZE_W;
        end else if (load_accept) begin
            off_q  <= addr[1:0];
            size_q <= mem_ctl.mem_size;
        end
    end

    assign rd_byte = dmem_rdata[{off_q, 3'b000} +: 8];
    assign rd_half = dmem_rdata[{off_q[1], 4'b0000} +: 16];

    always_comb begin
        case (size_q)
            SIZE_B:  load_data = {{(XLEN-8){rd_byte[7]}}, rd_byte};
            SIZE_BU: load_data = {{(XLEN-8){1'b0}}, rd_byte};
            SIZE_H:  load_data = {{(XLEN-16){rd_half[15]}}, rd_half};
            SIZE_HU: load_data = {{(XLEN-16){1'b0}}, rd_half};
            default: begin
                load_data = dmem_rdata;        // Word
            end
        endcase
    end

endmodule

`default_nettype wire

// File: hw/pipe_regs.sv
`timescale 1ns/10ps
`default_nettype none

module pipe_regs (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      stall,
    input  exec_pkg::lane_ex_t        ex_a,
    input  exec_pkg::lane_ex_t        ex_b,
    input  logic [exec_pkg::XLEN-1:0] alu_a,
    input  logic [exec_pkg::XLEN-1:0] alu_b,
    input  exec_pkg::mem_ctl_t        mem_ctl,
    input  logic [exec_pkg::XLEN-1:0] load_data,   // Aligned load result in MEM
    output exec_pkg::wb_port_t        mem_a,
    output exec_pkg::wb_port_t        mem_b,
    output exec_pkg::wb_port_t        wb_a,
    output exec_pkg::wb_port_t        wb_b
);

    import exec_pkg::*;

    wb_port_t mem_a_q;
    wb_port_t mem_b_q;                         // wdata holds the ALU result
    logic     mem_b_load;

    // EX/MEM, a stall pushes a bubble while EX holds its pair
    always_ff @(posedge clk) begin
        if (rst) begin
            mem_a_q.we <= 1'b0;
            mem_b_q.we <= 1'b0;
            mem_b_load <= 1'b0;
        end else begin
            mem_a_q.we <= ex_a.rf_we && !stall;
            mem_b_q.we <= ex_b.rf_we && !stall;
            mem_b_load <= (mem_ctl.mem_op == MEM_LOAD) && !stall;
        end
        mem_a_q.waddr <= ex_a.waddr;
        mem_a_q.wdata <= alu_a;
        mem_b_q.waddr <= ex_b.waddr;
        mem_b_q.wdata <= alu_b;
    end

    assign mem_a = mem_a_q;

    // Lane B writeback select, also the value seen by forwarding
    always_comb begin
        mem_b.we    = mem_b_q.we;
        mem_b.waddr = mem_b_q.waddr;
        mem_b.wdata = mem_b_load ? load_data : mem_b_q.wdata;
    end

    // MEM/WB keeps moving through a stall
    always_ff @(posedge clk) begin
        if (rst) begin
            wb_a.we <= 1'b0;
            wb_b.we <= 1'b0;
        end else begin
            wb_a.we <= mem_a.we;
            wb_b.we <= mem_b.we;
        end
        wb_a.waddr <= mem_a.waddr;
        wb_a.wdata <= mem_a.wdata;
        wb_b.waddr <= mem_b.waddr;
        wb_b.wdata <= mem_b.wdata;
    end

endmodule

`default_nettype wire

// File: hw/ex_mem_wb.sv
`timescale 1ns/10ps
`default_nettype none

module ex_mem_wb (
    input  logic                      clk,
    input  logic                      rst,
    input  exec_pkg::lane_ex_t        ex_a,        // Older lane
    input  exec_pkg::lane_ex_t        ex_b,        // Younger lane, owns memory
    input  exec_pkg::mem_ctl_t        ex_mem_b,
    output logic                      stall,       // Issue holds EX inputs while high
    output logic                      dmem_valid,
    output exec_pkg::dmem_req_t       dmem_req,
    input  logic                      dmem_ready,
    input  logic [exec_pkg::XLEN-1:0] dmem_rdata,  // Valid the cycle after accept
    output exec_pkg::wb_port_t        wb_a,
    output exec_pkg::wb_port_t        wb_b
);

    import exec_pkg::*;

    logic [XLEN-1:0] op_a1;
    logic [XLEN-1:0] op_a2;
    logic [XLEN-1:0] op_b1;
    logic [XLEN-1:0] op_b2;
    logic [XLEN-1:0] alu_a;
    logic [XLEN-1:0] alu_b;
    logic [XLEN-1:0] load_data;
    wb_port_t        mem_a;
    wb_port_t        mem_b;

    operand_forward forward_i (
        .ex_a  (ex_a),
        .ex_b  (ex_b),
        .mem_a (mem_a),
        .mem_b (mem_b),
        .wb_a  (wb_a),
        .wb_b  (wb_b),
        .op_a1 (op_a1),
        .op_a2 (op_a2),
        .op_b1 (op_b1),
        .op_b2 (op_b2)
    );

    int_alu alu_a_i (.lane(ex_a), .op1(op_a1), .op2(op_a2), .result(alu_a));
    int_alu alu_b_i (.lane(ex_b), .op1(op_b1), .op2(op_b2), .result(alu_b));

    load_store_unit lsu_i (
        .clk        (clk),
        .rst        (rst),
        .addr       (alu_b),
        .store_data (op_b2),
        .mem_ctl    (ex_mem_b),
        .dmem_ready (dmem_ready),
        .dmem_rdata (dmem_rdata),
        .dmem_valid (dmem_valid),
        .dmem_req   (dmem_req),
        .stall      (stall),
        .load_data  (load_data)
    );

    pipe_regs regs_i (
        .clk       (clk),
        .rst       (rst),
        .stall     (stall),
        .ex_a      (ex_a),
        .ex_b      (ex_b),
        .alu_a     (alu_a),
        .alu_b     (alu_b),
        .mem_ctl   (ex_mem_b),
        .load_data (load_data),
        .mem_a     (mem_a),
        .mem_b     (mem_b),
        .wb_a      (wb_a),
        .wb_b      (wb_b)
    );

endmodule

`default_nettype wire

// File: bench/tb_vectors.svh
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// Per lane: alu_op, src1, src2, raddr1, raddr2, imm, waddr (-1 = no write), expected wdata
// Then lane B memory: mem_op, size, expected addr, expected store data, expected strobe
// Lane A pc is 0x100 + 8 * row, lane B pc is 4 more
task automatic load_vectors();
    add_row("lui addi", ALU_LUI, SRC1_RF, SRC2_IMM, 0, 0, 32'h12345000, 1, 32'h12345000,
        ALU_ADD, SRC1_RF, SRC2_IMM, 0, 0, 32'h678, 2, 32'h678, MEM_NONE, SIZE_W, 0, 0, 0);
    add_row("fwd mem", ALU_ADD, SRC1_RF, SRC2_RF, 1, 2, 0, 3, 32'h12345678,
        ALU_SUB, SRC1_RF, SRC2_RF, 2, 1, 0, 4, 32'hedcbb678, MEM_NONE, SIZE_W, 0, 0, 0);
    add_row("fwd wb", ALU_XOR, SRC1_RF, SRC2_RF, 1, 3, 0, 5, 32'h00000678,
        ALU_OR, SRC1_RF, SRC2_RF, 4, 2, 0, 6, 32'hedcbb678, MEM_NONE, SIZE_W, 0, 0, 0);
    add_row("same dst", ALU_ADD, SRC1_RF, SRC2_IMM, 0, 0, 32'h11, 7, 32'h11,
        ALU_ADD, SRC1_RF, SRC2_IMM, 0, 0, 32'h22, 7, 32'h22, MEM_NONE, SIZE_W, 0, 0, 0);
    add_row("b wins", ALU_ADD, SRC1_RF, SRC2_IMM, 7, 0, 32'h100, 7, 32'h122,
        ALU_NOR, SRC1_RF, SRC2_RF, 0, 5, 0, 9, 32'hfffff987, MEM_NONE, SIZE_W, 0, 0, 0);
    add_row("mem>wb", ALU_SUB, SRC1_RF, SRC2_RF, 7, 5, 0, 10, 32'hfffffaaa,
        ALU_SLT, SRC1_RF, SRC2_RF, 4, 5, 0, 11, 32'h1, MEM_NONE, SIZE_W, 0, 0, 0);
    add_row("sltu sll", ALU_SLTU, SRC1_RF, SRC2_RF, 5, 4, 0, 12, 32'h1,
        ALU_SLL, SRC1_RF, SRC2_IMM, 3, 0, 32'h24, 13, 32'h23456780, MEM_NONE, SIZE_W, 0, 0, 0);
    add_row("srl sra", ALU_SRL, SRC1_RF, SRC2_IMM, 4, 0, 32'h8, 14, 32'h00edcbb6,
        ALU_SRA, SRC1_RF, SRC2_IMM, 4, 0, 32'h8, 15, 32'hffedcbb6, MEM_NONE, SIZE_W, 0, 0, 0);
    add_row("pc ops", ALU_ADD, SRC1_PC, SRC2_IMM, 0, 0, 32'h10, 16, 32'h150,
        ALU_SUB, SRC1_PC, SRC2_RF, 0, 11, 0, 17, 32'h143, MEM_NONE, SIZE_W, 0, 0, 0);
    add_row("sra xor", ALU_SRA, SRC1_RF, SRC2_RF, 9, 11, 0, 18, 32'hfffffcc3,
        ALU_XOR, SRC1_PC, SRC2_IMM, 0, 0, 32'hff, 19, 32'h1b3, MEM_NONE, SIZE_W, 0, 0, 0);
    add_row("st w", ALU_OR, SRC1_RF, SRC2_RF, 14, 0, 0, 20, 32'h00edcbb6,
        ALU_ADD, SRC1_RF, SRC2_IMM, 0, 3, 32'h80, -1, 0, MEM_STORE, SIZE_W, 32'h80,
        32'h12345678, 4'hf);
    add_row("st b+1", ALU_AND, SRC1_RF, SRC2_IMM, 3, 0, 32'hff, 21, 32'h78,
        ALU_ADD, SRC1_RF, SRC2_IMM, 0, 9, 32'h85, -1, 0, MEM_STORE, SIZE_B, 32'h85,
        32'h87878787, 4'h2);
    add_row("st h+2", ALU_ADD, SRC1_RF, SRC2_RF, 20, 21, 0, 22, 32'h00edcc2e,
        ALU_ADD, SRC1_RF, SRC2_IMM, 0, 10, 32'h86, -1, 0, MEM_STORE, SIZE_H, 32'h86,
        32'hfaaafaaa, 4'hc);
    // Lane A writes r0, the next rows address through r0
    add_row("ld b+3", ALU_ADD, SRC1_RF, SRC2_IMM, 0, 0, 32'h55, 0, 32'h55,
        ALU_ADD, SRC1_RF, SRC2_IMM, 0, 0, 32'h83, 23, 32'h12, MEM_LOAD, SIZE_B, 32'h83, 0, 0);
    add_row("ld bu", ALU_ADD, SRC1_RF, SRC2_IMM, 23, 0, 32'h1, 24, 32'h13,
        ALU_ADD, SRC1_RF, SRC2_IMM, 0, 0, 32'h85, 25, 32'h87, MEM_LOAD, SIZE_BU, 32'h85, 0, 0);
    add_row("ld h", ALU_ADD, SRC1_RF, SRC2_RF, 25, 24, 0, 26, 32'h9a,
        ALU_ADD, SRC1_RF, SRC2_IMM, 0, 0, 32'h86, 27, 32'hfffffaaa, MEM_LOAD, SIZE_H, 32'h86,
        0, 0);
    add_row("ld hu", ALU_ADD, SRC1_RF, SRC2_RF, 0, 0, 0, -1, 0,
        ALU_ADD, SRC1_RF, SRC2_IMM, 0, 0, 32'h86, 28, 32'hfaaa, MEM_LOAD, SIZE_HU, 32'h86, 0, 0);
    add_row("ld b+1", ALU_XOR, SRC1_RF, SRC2_RF, 27, 28, 0, 30, 32'hffff0000,
        ALU_ADD, SRC1_RF, SRC2_IMM, 0, 0, 32'h85, 29, 32'hffffff87, MEM_LOAD, SIZE_B, 32'h85,
        0, 0);
    add_row("ld w", ALU_LUI, SRC1_RF, SRC2_IMM, 0, 0, 32'habcd0000, 8, 32'habcd0000,
        ALU_ADD, SRC1_RF, SRC2_IMM, 0, 0, 32'h80, 31, 32'h12345678, MEM_LOAD, SIZE_W, 32'h80,
        0, 0);
    add_row("st h+0", ALU_SLL, SRC1_RF, SRC2_RF, 31, 11, 0, 1, 32'h2468acf0,
        ALU_ADD, SRC1_RF, SRC2_IMM, 0, 31, 32'h88, -1, 0, MEM_STORE, SIZE_H, 32'h88,
        32'h56785678, 4'h3);
    add_row("ld hu+0", ALU_AND, SRC1_RF, SRC2_RF, 1, 18, 0, 3, 32'h2468acc0,
        ALU_ADD, SRC1_RF, SRC2_IMM, 0, 0, 32'h88, 2, 32'h5678, MEM_LOAD, SIZE_HU, 32'h88, 0, 0);
endtask

`endif

// File: bench/tb_ex_mem_wb.sv
`timescale 1ns/10ps
`default_nettype none

module tb_ex_mem_wb;

    import exec_pkg::*;

    typedef struct packed {
        alu_op_e   op;
        src1_sel_e s1;
        src2_sel_e s2;
        logic [4:0]  r1;
        logic [4:0]  r2;
        logic [31:0] imm;
        logic        we;                        // Lane writes a register
        logic [4:0]  wa;
        logic [31:0] exp;
    } lane_vec_t;

    typedef struct packed {
        mem_ctl_t    ctl;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  strb;
    } mem_vec_t;

    logic        clk;
    logic        rst;
    lane_ex_t    ex_a;
    lane_ex_t    ex_b;
    mem_ctl_t    ex_mem_b;
    logic        stall;
    logic        dmem_valid;
    dmem_req_t   dmem_req;
    logic        dmem_ready;
    logic [31:0] dmem_rdata;
    wb_port_t    wb_a;
    wb_port_t    wb_b;

    lane_vec_t   va[$];
    lane_vec_t   vb[$];
    mem_vec_t    vm[$];
    string       vname[$];
    logic [31:0] regs[32];                      // Architectural state seen by issue
    logic [31:0] mem[256];
    logic [31:0] lfsr;
    int          row_err[64];
    int          errors;
    int          cycles = 0;
    int          limit = 1000;
    int          idx;
    int          mem_row;
    int          wb_row;
    bit          active;
    bit          acc;

    ex_mem_wb dut_i (
        .clk(clk), .rst(rst), .ex_a(ex_a), .ex_b(ex_b), .ex_mem_b(ex_mem_b), .stall(stall),
        .dmem_valid(dmem_valid), .dmem_req(dmem_req), .dmem_ready(dmem_ready),
        .dmem_rdata(dmem_rdata), .wb_a(wb_a), .wb_b(wb_b)
    );

    `include "tb_vectors.svh"

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Memory with one cycle read latency
    always @(posedge clk) begin
        if (dmem_valid && dmem_ready) begin
            if (dmem_req.we) begin
                for (int i = 0; i < 4; i++) begin
                    if (dmem_req.wstrb[i]) begin
                        mem[dmem_req.addr[9:2]][8*i +: 8] <= dmem_req.wdata[8*i +: 8];
                    end
                end
            end else begin
                dmem_rdata <= mem[dmem_req.addr[9:2]];
            end
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > limit) begin
            $display("Timeout: the run did not finish within %0d cycles", limit);
            $display("Finished with errors");
            $finish;
        end
    end

    function automatic lane_vec_t make_lane(input alu_op_e op, input src1_sel_e s1,
            input src2_sel_e s2, input int r1, input int r2, input logic [31:0] imm,
            input int wa, input logic [31:0] exp);
        lane_vec_t v;
        v.op  = op;
        v.s1  = s1;
        v.s2  = s2;
        v.r1  = r1[4:0];
        v.r2  = r2[4:0];
        v.imm = imm;
        v.we  = (wa >= 0);
        v.wa  = wa[4:0];
        v.exp = exp;
        return v;
    endfunction

    task automatic add_row(input string name, input alu_op_e aop, input src1_sel_e as1,
            input src2_sel_e as2, input int ar1, input int ar2, input logic [31:0] aimm,
            input int awa, input logic [31:0] aexp, input alu_op_e bop, input src1_sel_e bs1,
            input src2_sel_e bs2, input int br1, input int br2, input logic [31:0] bimm,
            input int bwa, input logic [31:0] bexp, input mem_op_e mop, input mem_size_e msz,
            input logic [31:0] maddr, input logic [31:0] mwdata, input int mstrb);
        mem_vec_t m;
        m.ctl.mem_op   = mop;
        m.ctl.mem_size = msz;
        m.addr  = maddr;
        m.wdata = mwdata;
        m.strb  = mstrb[3:0];
        vname.push_back(name);
        va.push_back(make_lane(aop, as1, as2, ar1, ar2, aimm, awa, aexp));
        vb.push_back(make_lane(bop, bs1, bs2, br1, br2, bimm, bwa, bexp));
        vm.push_back(m);
    endtask

    function automatic logic lfsr_bit();
        logic nb;
        nb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], nb};
        return nb;
    endfunction

    // Register data comes from the bench's file, stale while writes are in flight
    function automatic lane_ex_t to_lane(input lane_vec_t v, input logic [31:0] pc);
        lane_ex_t l;
        l.pc       = pc;
        l.rdata1   = regs[v.r1];
        l.rdata2   = regs[v.r2];
        l.raddr1   = v.r1;
        l.raddr2   = v.r2;
        l.imm      = v.imm;
        l.src1_sel = v.s1;
        l.src2_sel = v.s2;
        l.alu_op   = v.op;
        l.rf_we    = v.we;
        l.waddr    = v.wa;
        return l;
    endfunction

    task automatic drive();
        logic b0;
        logic b1;
        active = (idx < va.size());
        if (active) begin
            ex_a     = to_lane(va[idx], 32'h100 + idx * 8);
            ex_b     = to_lane(vb[idx], 32'h104 + idx * 8);
            ex_mem_b = vm[idx].ctl;
        end else begin
            ex_a     = '0;
            ex_b     = '0;
            ex_mem_b = '0;
        end
        b0 = lfsr_bit();
        b1 = lfsr_bit();
        dmem_ready = !(b0 & b1);                // Low about a quarter of the time
    endtask

    task automatic fail(input string msg);
        $display("** Error at %0t: %s", $time, msg);
        errors++;
        if (active) begin
            row_err[idx]++;
        end
    endtask

    task automatic check_req();
        logic exp_valid;
        exp_valid = active && (vm[idx].ctl.mem_op != MEM_NONE);
        if (dmem_valid !== exp_valid) begin
            fail($sformatf("dmem_valid %b, expected %b", dmem_valid, exp_valid));
        end
        if (stall !== (exp_valid && !dmem_ready)) begin
            fail($sformatf("stall %b with valid %b ready %b", stall, exp_valid, dmem_ready));
        end
        if (exp_valid) begin
            if (dmem_req.addr !== vm[idx].addr || dmem_req.wstrb !== vm[idx].strb) begin
                fail($sformatf("request addr %h strb %h, expected %h %h", dmem_req.addr,
                    dmem_req.wstrb, vm[idx].addr, vm[idx].strb));
            end
            if (vm[idx].ctl.mem_op == MEM_STORE && dmem_req.wdata !== vm[idx].wdata) begin
                fail($sformatf("store data %h, expected %h", dmem_req.wdata, vm[idx].wdata));
            end
            if (dmem_req.we !== (vm[idx].ctl.mem_op == MEM_STORE)) begin
                fail($sformatf("request we %b is wrong", dmem_req.we));
            end
        end
        acc = active && !stall;
    endtask

    task automatic check_port(input wb_port_t p, input lane_vec_t v, input string lane,
            input int r);
        if (p.we !== v.we || (p.we && (p.waddr !== v.wa || p.wdata !== v.exp))) begin
            $display("** Error at %0t: row %0d lane %s wrote we=%b r%0d=%h, expected %b r%0d=%h",
                $time, r, lane, p.we, p.waddr, p.wdata, v.we, v.wa, v.exp);
            errors++;
            row_err[r]++;
        end
    endtask

    task automatic check_wb(input int r);
        if (r < 0) begin
            if (wb_a.we !== 1'b0 || wb_b.we !== 1'b0) begin
                fail("register write with no row retiring");
            end
        end else begin
            check_port(wb_a, va[r], "A", r);
            check_port(wb_b, vb[r], "B", r);
            $display("Row %0d %s %s", r, vname[r], (row_err[r] == 0) ? "pass" : "FAIL");
        end
    endtask

    // A row leaving WB writes the register file, r0 stays zero
    task automatic retire_row(input int r);
        if (r >= 0) begin
            if (va[r].we && va[r].wa != 0) begin
                regs[va[r].wa] = va[r].exp;
            end
            if (vb[r].we && vb[r].wa != 0) begin
                regs[vb[r].wa] = vb[r].exp;     // Lane B is younger
            end
        end
    endtask

    initial begin
        rst        = 1'b1;
        ex_a       = '0;
        ex_b       = '0;
        ex_mem_b   = '0;
        dmem_ready = 1'b0;
        dmem_rdata = '0;
        lfsr       = 32'h59e5_560d;
        errors     = 0;
        idx        = 0;
        mem_row    = -1;
        wb_row     = -1;
        active     = 0;
        acc        = 0;
        for (int i = 0; i < 256; i++) begin
            mem[i] = i * 32'h0101_0101 ^ 32'h5a3c_96e1;
        end
        for (int i = 0; i < 32; i++) begin
            regs[i] = '0;
        end
        for (int i = 0; i < 64; i++) begin
            row_err[i] = 0;
        end
        load_vectors();
        limit = 10 + 8 * va.size() + 20;
        repeat (10) @(posedge clk);
        #1 rst = 1'b0;
        repeat (2) begin                        // Quiet outputs before the first row
            @(negedge clk);
            check_req();
            @(posedge clk);
            #1;
            check_wb(-1);
        end
        drive();
        while (wb_row != va.size() - 1) begin
            @(negedge clk);
            check_req();
            @(posedge clk);
            #1;
            retire_row(wb_row);
            wb_row  = mem_row;                  // Two edges from EX to WB
            mem_row = acc ? idx : -1;
            if (acc) begin
                idx++;
            end
            check_wb(wb_row);
            drive();
        end
        $display("Rows: %0d, cycles: %0d, errors: %0d", va.size(), cycles, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+bench
hw/exec_pkg.sv
hw/operand_forward.sv
hw/int_alu.sv
hw/load_store_unit.sv
hw/pipe_regs.sv
hw/ex_mem_wb.sv
bench/tb_ex_mem_wb.sv

// File: run_sim.sh
#!/bin/sh
# Build the bench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_ex_mem_wb -f vlog.f -o tb_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/tb_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "Finished with no errors"; then
    exit 0
fi
exit 1
